// File: src/addtree_defines.svh
// ********************
// adder tree constants
// widths, element count and pipeline timing
// ********************
`ifndef ADDTREE_DEFINES_SVH
`define ADDTREE_DEFINES_SVH

// element and lane width
`define ELEM_W 16

// elements per input vector
// an odd count leaves one element for the bypass path
`define N_ELEM 25

// pipeline depth of one two-lane adder
`define ADD_LAT 2

// input valid to output valid of one layer
`define LAYER_LAT (`ADD_LAT + 3)

// odd element skips layers 0 and 1
`define ODD_DELAY (2 * `LAYER_LAT)

// strobes may not come closer than one layer latency
`define MIN_GAP `LAYER_LAT

`endif

// File: src/addtree_pkg.sv
// ********************
// adder tree types
// element, packed lane pair and input vector
// ********************
`include "addtree_defines.svh"

package addtree_pkg;

    // one unsigned element
    typedef logic [`ELEM_W-1:0] elem_t;

    // two lanes sharing one 32-bit adder word
    // hi lane sits in the upper half, as on the packed DSP
    typedef struct packed {
        elem_t hi;
        elem_t lo;
    } pair_t;

    // full input vector
    // element 24 is the odd one that bypasses layers 0 and 1
    typedef elem_t [`N_ELEM-1:0] in_vec_t;

endpackage

// File: src/pair_adder.sv
// ********************
// two-lane 16-bit adder
// lanes add separately with no carry between them
// ********************
`timescale 1ns/10ps
`include "addtree_defines.svh"

module pair_adder (
    input  logic                clk,
    input  logic                en,
    input  addtree_pkg::pair_t  a,
    input  addtree_pkg::pair_t  b,
    output addtree_pkg::pair_t  sum
);
    import addtree_pkg::*;

    // adder pipeline
    // stage 0 holds the raw lane sums
    pair_t pipe [`ADD_LAT];

    // ********************
    // lane sums
    // ********************

    // en acts like the DSP clock enable and stalls the whole pipe
    always_ff @(posedge clk) begin
        if (en) begin
            // each lane wraps modulo 2^16 on its own
            pipe[0].lo <= a.lo + b.lo;
            pipe[0].hi <= a.hi + b.hi;
            for (int k = 1; k < `ADD_LAT; k++) begin
                pipe[k] <= pipe[k-1];
            end
        end
    end

    // last stage is the adder result
    assign sum = pipe[`ADD_LAT-1];

endmodule

// File: src/tree_layer.sv
// ********************
// one adder tree layer
// adder array, busy shift control and held result
// ********************
`timescale 1ns/10ps
`include "addtree_defines.svh"

module tree_layer #(
    parameter int N_ADD = 1
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  addtree_pkg::pair_t [N_ADD-1:0]  in_a,
    input  addtree_pkg::pair_t [N_ADD-1:0]  in_b,
    output logic                            out_valid,
    output addtree_pkg::pair_t [N_ADD-1:0]  out_sum
);
    import addtree_pkg::*;

    // enable window plus one strobe bit
    localparam int BUSY_W = `LAYER_LAT - 1;

    logic [BUSY_W-1:0]  busy;
    logic               adder_en;
    logic               res_strobe;
    pair_t [N_ADD-1:0]  add_sum;

    // ********************
    // busy control
    // ********************

    // a 1 enters on the cycle after in_valid and walks up one bit per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= '0;
        end else begin
            busy <= {busy[BUSY_W-2:0], in_valid};
        end
    end

    // adders run for ADD_LAT+1 cycles
    // one more than the latency so the sum settles before capture
    assign adder_en = |busy[`ADD_LAT:0];

    // top bit marks the cycle the sum is taken
    assign res_strobe = busy[`ADD_LAT+1];

    // ********************
    // adder array
    // ********************

    for (genvar i = 0; i < N_ADD; i++) begin : g_add
        pair_adder u_add (
            .clk (clk),
            .en  (adder_en),
            .a   (in_a[i]),
            .b   (in_b[i]),
            .sum (add_sum[i])
        );
    end

    // ********************
    // held result
    // ********************

    // result stays put until the next vector reaches this layer
    // next layer reads it as a stable operand
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            out_sum   <= '0;
        end else begin
            out_valid <= res_strobe;
            if (res_strobe) begin
                out_sum <= add_sum;
            end
        end
    end

    // upstream spacing must keep vectors from overlapping in one layer
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst)
        in_valid |-> (busy == '0)
    ) else $error("tree_layer: new vector while layer still busy");

endmodule

// File: src/operand_stage.sv
// ********************
// operand stage
// captures the input vector and feeds layer 0 and the odd path
// ********************
`timescale 1ns/10ps
`include "addtree_defines.svh"

module operand_stage (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    in_valid,
    input  addtree_pkg::in_vec_t                    in_data,
    output logic                                    l0_valid,
    output addtree_pkg::pair_t [`N_ELEM/2-1:0]      l0_words,
    output addtree_pkg::elem_t                      odd_elem
);
    import addtree_pkg::*;

    localparam int N_WORD = `N_ELEM / 2;

    // captured vector held until the next strobe
    in_vec_t vec_q;

    // odd element delay line
    elem_t odd_line [`ODD_DELAY];

    // ********************
    // input capture
    // ********************

    always_ff @(posedge clk) begin
        if (in_valid) begin
            vec_q <= in_data;
        end
    end

    // layer 0 sees the vector one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst) begin
            l0_valid <= 1'b0;
        end else begin
            l0_valid <= in_valid;
        end
    end

    // pack neighbours into one adder word
    // even element in lo, odd element in hi
    always_comb begin
        for (int k = 0; k < N_WORD; k++) begin
            l0_words[k].lo = vec_q[2*k];
            l0_words[k].hi = vec_q[2*k+1];
        end
    end

    // ********************
    // odd element path
    // ********************

    // free running shift from the held vector
    // output lands on the cycle layer 1 hands its sums to layer 2
    always_ff @(posedge clk) begin
        odd_line[0] <= vec_q[`N_ELEM-1];
        for (int k = 1; k < `ODD_DELAY; k++) begin
            odd_line[k] <= odd_line[k-1];
        end
    end

    assign odd_elem = odd_line[`ODD_DELAY-1];

    // closer strobes would overrun the busy window of layer 0
    // and shift the odd element away before layer 2 uses it
    for (genvar k = 1; k < `MIN_GAP; k++) begin : g_gap_chk
        a_min_gap: assert property (
            @(posedge clk) disable iff (!rst)
            in_valid |-> !$past(in_valid, k)
        ) else $error("operand_stage: in_valid %0d cycles after previous strobe", k);
    end

endmodule

// File: src/adder_tree_25.sv
// ********************
// 25-element pipelined adder tree
// sums 25 unsigned 16-bit elements modulo 2^16
// ********************
`timescale 1ns/10ps

module adder_tree_25 (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  addtree_pkg::in_vec_t    in_data,
    output logic                    res_valid,
    output addtree_pkg::elem_t      res
);
    import addtree_pkg::*;

    // operand stage outputs
    logic       l0_valid;
    pair_t [11:0] l0_words;
    elem_t      odd_elem;

    // layer outputs with their valids and held sums
    logic       l0_out_valid;
    logic       l1_out_valid;
    logic       l2_out_valid;
    logic       l3_out_valid;
    pair_t [5:0] l0_sum;
    pair_t [2:0] l1_sum;
    pair_t [1:0] l2_sum;
    pair_t [0:0] l3_sum;
    pair_t [0:0] l4_sum;

    // operands built from several sources
    pair_t [1:0] l2_b;
    pair_t [0:0] fold_a;
    pair_t [0:0] fold_b;

    operand_stage u_ops (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .l0_valid (l0_valid),
        .l0_words (l0_words),
        .odd_elem (odd_elem)
    );

    // ********************
    // layers 0 and 1
    // ********************

    // word i plus word i+6
    tree_layer #(.N_ADD(6)) u_l0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (l0_valid),
        .in_a      (l0_words[5:0]),
        .in_b      (l0_words[11:6]),
        .out_valid (l0_out_valid),
        .out_sum   (l0_sum)
    );

    // word i plus word i+3
    tree_layer #(.N_ADD(3)) u_l1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (l0_out_valid),
        .in_a      (l0_sum[2:0]),
        .in_b      (l0_sum[5:3]),
        .out_valid (l1_out_valid),
        .out_sum   (l1_sum)
    );

    // ********************
    // layer 2 where the odd element joins
    // ********************

    assign l2_b[0] = l1_sum[2];
    // odd element rides alone in the lo lane
    assign l2_b[1] = '{hi: '0, lo: odd_elem};

    tree_layer #(.N_ADD(2)) u_l2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (l1_out_valid),
        .in_a      (l1_sum[1:0]),
        .in_b      (l2_b),
        .out_valid (l2_out_valid),
        .out_sum   (l2_sum)
    );

    tree_layer #(.N_ADD(1)) u_l3 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (l2_out_valid),
        .in_a      (l2_sum[0:0]),
        .in_b      (l2_sum[1:1]),
        .out_valid (l3_out_valid),
        .out_sum   (l3_sum)
    );

    // ********************
    // final lane fold
    // ********************

    // both lanes moved to lo so the last add gives the full sum
    assign fold_a[0] = '{hi: '0, lo: l3_sum[0].lo};
    assign fold_b[0] = '{hi: '0, lo: l3_sum[0].hi};

    tree_layer #(.N_ADD(1)) u_l4 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (l3_out_valid),
        .in_a      (fold_a),
        .in_b      (fold_b),
        .out_valid (res_valid),
        .out_sum   (l4_sum)
    );

    // held in layer 4 until the next result
    assign res = l4_sum[0].lo;

endmodule

// File: tests/tb_adder_tree.sv
// ********************
// testbench for the 25-element adder tree
// directed tests, reference sums and latency checks
// ********************
`timescale 1ns/10ps
`include "addtree_defines.svh"

module tb_adder_tree;
    import addtree_pkg::*;

    // strobe to result through the operand stage and five layers
    localparam int LATENCY   = 1 + 5 * `LAYER_LAT;
    localparam int RESET_CYC = 10;
    localparam int IDLE_CYC  = 20;
    localparam int HOLD_CYC  = 8;
    localparam int N_SINGLE  = 3;
    localparam int N_RAND    = 20;

    // single vectors run alone
    // random ones overlap at MIN_GAP spacing
    localparam int WATCHDOG_CYC = RESET_CYC + IDLE_CYC
                                + N_SINGLE * (LATENCY + HOLD_CYC + `MIN_GAP)
                                + N_RAND * `MIN_GAP + LATENCY + 40;

    logic    clk;
    logic    rst;
    logic    in_valid;
    in_vec_t in_data;
    logic    res_valid;
    elem_t   res;

    // free running cycle count read only on falling edges
    int cyc = 0;
    int seed = 28854;

    adder_tree_25 dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .res_valid (res_valid),
        .res       (res)
    );

    // ********************
    // clock and watchdog
    // ********************

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        abort_run();
    end

    // ********************
    // helpers
    // ********************

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_sum(input elem_t got, input elem_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, res got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, res_valid got %b expected %b",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    // reference sum of all 25 elements wrapped to 16 bits
    function automatic elem_t sum_ref(input in_vec_t v);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < `N_ELEM; i++) begin
            acc = acc + 32'(v[i]);
        end
        return acc[`ELEM_W-1:0];
    endfunction

    function automatic in_vec_t fill_vec(input elem_t val);
        in_vec_t v;
        for (int i = 0; i < `N_ELEM; i++) begin
            v[i] = val;
        end
        return v;
    endfunction

    // one cycle strobe
    // t0 is the count seen while in_valid is high
    task automatic strobe_vector(input in_vec_t v, output int t0);
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= v;
        @(negedge clk);
        t0 = cyc;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // drive one vector alone, wait for its pulse, then watch res hold
    task automatic run_single(input in_vec_t v, input elem_t exp, input string name);
        int   t0;
        logic seen;
        seen = 1'b0;
        strobe_vector(v, t0);
        for (int n = 0; n < LATENCY + 10 && !seen; n++) begin
            @(negedge clk);
            // pulse must land on exactly the latency cycle
            check_valid(res_valid, (cyc - t0) == LATENCY, {name, " pulse timing"});
            if (res_valid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("timeout: %s never raised res_valid", name);
            abort_run();
        end
        check_sum(res, exp, {name, " sum"});
        repeat (HOLD_CYC) begin
            @(negedge clk);
            check_valid(res_valid, 1'b0, {name, " idle after pulse"});
            check_sum(res, exp, {name, " held result"});
        end
    endtask

    // ********************
    // directed tests
    // ********************

    task automatic idle_after_reset();
        repeat (IDLE_CYC) begin
            @(negedge clk);
            check_valid(res_valid, 1'b0, "idle after reset");
            check_sum(res, '0, "idle after reset");
        end
    endtask

    task automatic all_ones_sum();
        run_single(fill_vec(16'd1), 16'd25, "all ones");
    endtask

    // only the odd element is set so it must come out unchanged
    task automatic odd_element_path();
        in_vec_t v;
        v = fill_vec('0);
        v[`N_ELEM-1] = 16'hA5C3;
        run_single(v, 16'hA5C3, "odd element only");
    endtask

    // 25 * 0xffff wraps to 0xffe7 when lanes stay separate
    task automatic lane_wraparound();
        run_single(fill_vec(16'hFFFF), 16'hFFE7, "all 0xffff");
    endtask

    // back-to-back vectors at minimum spacing with several in flight
    task automatic random_stream();
        elem_t exp_q[$];
        int    strobe_q[$];
        fork
            begin : drive
                in_vec_t v;
                int      rnd;
                int      t0;
                for (int n = 0; n < N_RAND; n++) begin
                    for (int i = 0; i < `N_ELEM; i++) begin
                        rnd = $random(seed);
                        v[i] = rnd[`ELEM_W-1:0];
                    end
                    strobe_vector(v, t0);
                    exp_q.push_back(sum_ref(v));
                    strobe_q.push_back(t0);
                    repeat (`MIN_GAP - 2) @(posedge clk);
                end
            end
            begin : watch
                int    got_cnt;
                int    waited;
                elem_t last;
                logic  exp_v;
                got_cnt = 0;
                waited  = 0;
                last    = '0;
                while (got_cnt < N_RAND) begin
                    @(negedge clk);
                    waited++;
                    if (waited > N_RAND * `MIN_GAP + LATENCY + 10) begin
                        $display("timeout: only %0d of %0d random results arrived",
                                 got_cnt, N_RAND);
                        abort_run();
                    end
                    // oldest outstanding strobe decides when the next pulse is due
                    exp_v = 1'b0;
                    if (strobe_q.size() > 0) begin
                        exp_v = (cyc == strobe_q[0] + LATENCY);
                    end
                    check_valid(res_valid, exp_v, "random stream pulse timing");
                    if (res_valid) begin
                        check_sum(res, exp_q[0], "random stream sum");
                        last = exp_q.pop_front();
                        void'(strobe_q.pop_front());
                        got_cnt++;
                    end else if (got_cnt > 0) begin
                        check_sum(res, last, "random stream held result");
                    end
                end
            end
        join
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        rst      = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b1;

        idle_after_reset();
        all_ones_sum();
        odd_element_path();
        lane_wraparound();
        random_stream();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/addtree_pkg.sv
src/pair_adder.sv
src/tree_layer.sv
src/operand_stage.sv
src/adder_tree_25.sv
tests/tb_adder_tree.sv

// File: run_sim.sh
#!/bin/sh
# build and run the adder tree testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_adder_tree -o tb_adder_tree
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_adder_tree > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
